//--- tb.f
hw/tracer_pkg.sv
hw/trace_decode.sv
hw/trace_execute.sv
hw/trace_result.sv
hw/instr_tracer.sv
testbench/instr_tracer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instr_tracer testbench with Verilator.
# Exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module instr_tracer_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vinstr_tracer_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
else
  echo "Simulation did not report a pass"
  exit 1
fi

//--- testbench/instr_tracer_tb.sv
// Directed testbench for instr_tracer; drives core views and checks records at a Wishbone sink
`timescale 1ns/1ps

module instr_tracer_tb;
  import tracer_pkg::*;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned MAX_CYCLES = 400;

  logic        clk_i;
  logic        rst_n;
  id_info_t    id_i;
  ex_info_t    ex_i;
  wb_info_t    wb_i;
  logic        wb_ack_i = 1'b0;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  seq_t        wb_adr_o;
  trace_rec_t  wb_dat_o;
  drop_cnt_t   dropped_o;

  integer      seed;
  int unsigned cycles = 0;
  int          errors = 0;
  int          bus_errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          total;
  logic        ack_hold;
  int unsigned ack_wait;
  int unsigned wait_cnt = 0;
  seq_t        rx_adr[$];
  trace_rec_t  rx_rec[$];

  instr_tracer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .id_i      (id_i),
    .ex_i      (ex_i),
    .wb_i      (wb_i),
    .wb_ack_i  (wb_ack_i),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_we_o   (wb_we_o),
    .wb_adr_o  (wb_adr_o),
    .wb_dat_o  (wb_dat_o),
    .dropped_o (dropped_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Wishbone sink that acks after ack_wait cycles unless held off
  // ------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_i <= 1'b0;
      wait_cnt <= 0;
    end else if (wb_ack_i) begin
      wb_ack_i <= 1'b0;
    end else if (wb_cyc_o && wb_stb_o && !ack_hold) begin
      if (wait_cnt >= ack_wait) begin
        wb_ack_i <= 1'b1;
        wait_cnt <= 0;
        rx_adr.push_back(wb_adr_o);
        rx_rec.push_back(wb_dat_o);
        if (!wb_we_o) begin
          $display("Wishbone transfer seen with write enable low");
          bus_errors++;
        end
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

  // Strobe and cycle rise and fall together
  always @(posedge clk_i) begin
    if (rst_n && (wb_stb_o !== wb_cyc_o)) begin
      $display("Wishbone strobe and cycle differ at cycle %0d", cycles);
      bus_errors++;
    end
  end

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------
  function automatic xlen_t next_data();
    return $random(seed);
  endfunction

  function automatic instr_t addi_word(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic instr_t sw_word(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t lw_word(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic id_info_t decoded(addr_t pc, instr_t instr, logic c);
    id_info_t d;
    d             = '0;
    d.id_valid    = 1'b1;
    d.is_decoding = 1'b1;
    d.pc          = pc;
    d.instr       = instr;
    d.compressed  = c;
    return d;
  endfunction

  function automatic ex_info_t ex_reg_write(reg_addr_t rd, xlen_t data);
    ex_info_t e;
    e           = '0;
    e.ex_valid  = 1'b1;
    e.reg_we    = 1'b1;
    e.reg_addr  = rd;
    e.reg_wdata = data;
    return e;
  endfunction

  function automatic ex_info_t ex_access(logic we, addr_t addr, xlen_t wdata);
    ex_info_t e;
    e            = '0;
    e.ex_valid   = 1'b1;
    e.data_req   = 1'b1;
    e.data_gnt   = 1'b1;
    e.data_we    = we;
    e.data_addr  = addr;
    e.data_wdata = wdata;
    return e;
  endfunction

  function automatic wb_info_t wb_retire(logic we, reg_addr_t rd, xlen_t data);
    wb_info_t w;
    w.wb_valid  = 1'b1;
    w.reg_we    = we;
    w.reg_addr  = rd;
    w.reg_wdata = data;
    return w;
  endfunction

  // Fields with no activity stay zero in a record
  function automatic trace_rec_t base_rec(addr_t pc, instr_t instr, logic c);
    trace_rec_t r;
    r            = '0;
    r.pc         = pc;
    r.instr      = instr;
    r.compressed = c;
    return r;
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n    <= 1'b0;
    id_i     <= '0;
    ex_i     <= '0;
    wb_i     <= '0;
    ack_hold = 1'b0;
    ack_wait = 0;
    repeat (2) @(posedge clk_i);
    rst_n <= 1'b1;
    rx_adr.delete();
    rx_rec.delete();
  endtask

  // One core cycle of ID, EX and WB views
  task automatic step(input id_info_t id, input ex_info_t ex, input wb_info_t wb);
    @(posedge clk_i);
    id_i <= id;
    ex_i <= ex;
    wb_i <= wb;
  endtask

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------
  task automatic compare_rec(input string name, input trace_rec_t exp, input trace_rec_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s record expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_seq(input string name, input seq_t exp, input seq_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s sequence expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_drop(input string name, input drop_cnt_t exp, input drop_cnt_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s drop count expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_next(input string name, input trace_rec_t exp, input seq_t exp_seq);
    seq_t       adr;
    trace_rec_t rec;
    while (rx_rec.size() == 0) @(posedge clk_i);
    adr = rx_adr.pop_front();
    rec = rx_rec.pop_front();
    compare_rec(name, exp, rec);
    compare_seq(name, exp_seq, adr);
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    $display("done %-18s %0d errors", name, errors - err0);
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic alu_test();
    int         err0;
    instr_t     ins;
    xlen_t      data;
    trace_rec_t exp;
    err0 = errors;
    apply_reset();
    ins  = addi_word(5'd3, 5'd1, 12'h07f);
    data = next_data();
    step(decoded(32'h100, ins, 1'b0), '0, '0);
    step('0, ex_reg_write(5'd3, data), '0);
    // A WB write belongs only to loads
    step('0, '0, wb_retire(1'b1, 5'd3, ~data));
    step('0, '0, '0);
    exp          = base_rec(32'h100, ins, 1'b0);
    exp.rd_we    = 1'b1;
    exp.rd_addr  = 5'd3;
    exp.rd_wdata = data;
    check_next("alu_instr", exp, 8'd0);
    report_test("alu_instr", err0);
  endtask

  task automatic store_load_test();
    int         err0;
    instr_t     st;
    instr_t     ld;
    xlen_t      sdata;
    xlen_t      ldata;
    ex_info_t   ex;
    trace_rec_t exp;
    err0  = errors;
    apply_reset();
    st    = sw_word(5'd6, 5'd2, 12'h010);
    ld    = lw_word(5'd9, 5'd2, 12'h010);
    sdata = next_data();
    ldata = next_data();
    // A stray write to the store's bits 11:7 must not attach
    ex           = ex_access(1'b1, 32'h1000_0010, sdata);
    ex.reg_we    = 1'b1;
    ex.reg_addr  = 5'd16;
    ex.reg_wdata = ldata;
    step(decoded(32'h200, st, 1'b0), '0, '0);
    step('0, ex, '0);
    step('0, '0, wb_retire(1'b0, 5'd0, '0));
    step(decoded(32'h204, ld, 1'b0), '0, '0);
    // Stale write data on the bus stays out of a read record
    step('0, ex_access(1'b0, 32'h1000_0010, sdata), '0);
    // Load data arrives with the WB write
    step('0, '0, wb_retire(1'b1, 5'd9, ldata));
    step('0, '0, '0);
    exp           = base_rec(32'h200, st, 1'b0);
    exp.mem_valid = 1'b1;
    exp.mem_we    = 1'b1;
    exp.mem_addr  = 32'h1000_0010;
    exp.mem_wdata = sdata;
    check_next("store", exp, 8'd0);
    exp           = base_rec(32'h204, ld, 1'b0);
    exp.mem_valid = 1'b1;
    exp.mem_addr  = 32'h1000_0010;
    exp.rd_we     = 1'b1;
    exp.rd_addr   = 5'd9;
    exp.rd_wdata  = ldata;
    check_next("load", exp, 8'd1);
    report_test("store_load", err0);
  endtask

  task automatic unmatched_write_test();
    int         err0;
    instr_t     ins;
    instr_t     cins;
    xlen_t      data;
    trace_rec_t exp;
    err0 = errors;
    apply_reset();
    ins  = addi_word(5'd5, 5'd1, 12'h001);
    // c.addi x11, 1 in the low half
    cins = 32'h0000_0585;
    data = next_data();
    step(decoded(32'h280, ins, 1'b0), '0, '0);
    step('0, ex_reg_write(5'd7, data), '0);
    step('0, '0, wb_retire(1'b0, 5'd0, '0));
    step(decoded(32'h284, cins, 1'b1), '0, '0);
    step('0, ex_reg_write(5'd7, data), '0);
    step('0, '0, wb_retire(1'b0, 5'd0, '0));
    step('0, '0, '0);
    exp = base_rec(32'h280, ins, 1'b0);
    check_next("unmatched_rd", exp, 8'd0);
    exp          = base_rec(32'h284, cins, 1'b1);
    exp.rd_we    = 1'b1;
    exp.rd_addr  = 5'd7;
    exp.rd_wdata = data;
    check_next("compressed_rd", exp, 8'd1);
    report_test("unmatched_write", err0);
  endtask

  task automatic back_to_back_test();
    int         err0;
    instr_t     ia;
    instr_t     ib;
    xlen_t      da;
    xlen_t      db;
    trace_rec_t exp;
    err0 = errors;
    apply_reset();
    ack_wait = 3;
    ia = addi_word(5'd4, 5'd0, 12'h011);
    ib = addi_word(5'd5, 5'd4, 12'h022);
    da = next_data();
    db = next_data();
    step(decoded(32'h300, ia, 1'b0), '0, '0);
    step(decoded(32'h304, ib, 1'b0), ex_reg_write(5'd4, da), '0);
    // B moves to WB in the same cycle that A retires
    step('0, ex_reg_write(5'd5, db), wb_retire(1'b0, 5'd0, '0));
    step('0, '0, wb_retire(1'b0, 5'd0, '0));
    step('0, '0, '0);
    exp          = base_rec(32'h300, ia, 1'b0);
    exp.rd_we    = 1'b1;
    exp.rd_addr  = 5'd4;
    exp.rd_wdata = da;
    check_next("back_to_back_a", exp, 8'd0);
    exp          = base_rec(32'h304, ib, 1'b0);
    exp.rd_we    = 1'b1;
    exp.rd_addr  = 5'd5;
    exp.rd_wdata = db;
    check_next("back_to_back_b", exp, 8'd1);
    report_test("back_to_back", err0);
  endtask

  task automatic overflow_test();
    int         err0;
    addr_t      pc;
    reg_addr_t  rd;
    instr_t     ins;
    xlen_t      data;
    trace_rec_t exp [7];
    err0 = errors;
    apply_reset();
    ack_hold = 1'b1;
    pc = 32'h400;
    for (int i = 0; i < 7; i++) begin
      // Six retire behind a stalled sink and the seventh after the drain
      if (i == 6) begin
        ack_hold = 1'b0;
        for (int k = 0; k < 4; k++) begin
          check_next("overflow_kept", exp[k], seq_t'(k));
        end
      end
      rd   = reg_addr_t'(i + 1);
      ins  = addi_word(rd, 5'd0, 12'(i));
      data = next_data();
      step(decoded(pc, ins, 1'b0), '0, '0);
      step('0, ex_reg_write(rd, data), '0);
      step('0, '0, wb_retire(1'b0, 5'd0, '0));
      step('0, '0, '0);
      exp[i]          = base_rec(pc, ins, 1'b0);
      exp[i].rd_we    = 1'b1;
      exp[i].rd_addr  = rd;
      exp[i].rd_wdata = data;
      pc = pc + 32'd4;
      if (i == 5) begin
        @(negedge clk_i);
        compare_drop("overflow_drops", 8'd2, dropped_o);
      end
    end
    check_next("overflow_next", exp[6], 8'd6);
    @(negedge clk_i);
    compare_drop("overflow_after", 8'd2, dropped_o);
    report_test("overflow", err0);
  endtask

  initial begin
    seed     = 32'he1a0;
    rst_n    = 1'b0;
    id_i     = '0;
    ex_i     = '0;
    wb_i     = '0;
    ack_hold = 1'b0;
    ack_wait = 0;
    alu_test();
    store_load_test();
    unmatched_write_test();
    back_to_back_test();
    overflow_test();
    total = errors + bus_errors;
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- hw/instr_tracer.sv
// Retire-trace top level; hook to the core's ID, EX and WB views and to a Wishbone trace sink
`timescale 1ns/1ps

module instr_tracer #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  tracer_pkg::id_info_t   id_i,
  input  tracer_pkg::ex_info_t   ex_i,
  input  tracer_pkg::wb_info_t   wb_i,
  input  logic                   wb_ack_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output tracer_pkg::seq_t       wb_adr_o,
  output tracer_pkg::trace_rec_t wb_dat_o,
  output tracer_pkg::drop_cnt_t  dropped_o
);
  import tracer_pkg::*;

  dec_evt_t   dec_evt;
  trace_rec_t ret_rec;
  logic       ret_valid;

  // Decode qualifier
  trace_decode u_decode (
    .id_i  (id_i),
    .evt_o (dec_evt)
  );

  // In-flight slots
  trace_execute u_execute (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .evt_i       (dec_evt),
    .ex_i        (ex_i),
    .wb_i        (wb_i),
    .rec_o       (ret_rec),
    .ret_valid_o (ret_valid)
  );

  // Buffering and bus output
  trace_result #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_result (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .rec_i       (ret_rec),
    .ret_valid_i (ret_valid),
    .wb_ack_i    (wb_ack_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .dropped_o   (dropped_o)
  );

endmodule

//--- hw/trace_result.sv
// Record FIFO with sequence and drop counters; drains retire records as Wishbone classic writes
`timescale 1ns/1ps

module trace_result #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  tracer_pkg::trace_rec_t rec_i,
  input  logic                   ret_valid_i,
  input  logic                   wb_ack_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output tracer_pkg::seq_t       wb_adr_o,
  output tracer_pkg::trace_rec_t wb_dat_o,
  output tracer_pkg::drop_cnt_t  dropped_o
);
  import tracer_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_e;

  logic [REC_W-1:0] rec_mem [FIFO_DEPTH];
  seq_t             seq_mem [FIFO_DEPTH];
  logic [PTR_W:0]   wr_ptr_q;
  logic [PTR_W:0]   rd_ptr_q;
  logic             fifo_empty;
  logic             fifo_full;
  logic             push;
  logic             pop;
  seq_t             seq_q;
  drop_cnt_t        drop_q;
  wb_state_e        state_q;
  wb_state_e        state_d;

  // ------------------------------------------------------------------
  // Record FIFO, pointers carry one wrap bit
  // ------------------------------------------------------------------
  assign fifo_empty = (wr_ptr_q == rd_ptr_q);
  assign fifo_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                      (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

  assign push = ret_valid_i && !fifo_full;
  // Head stays in place until the sink acknowledges it
  assign pop  = (state_q == WB_BUSY) && wb_ack_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      rec_mem[wr_ptr_q[PTR_W-1:0]] <= rec_i;
      seq_mem[wr_ptr_q[PTR_W-1:0]] <= seq_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      seq_q    <= '0;
      drop_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Sequence advances on drops too, so the sink sees the gap
      if (ret_valid_i) begin
        seq_q <= seq_q + 1'b1;
      end
      if (ret_valid_i && fifo_full && (drop_q != '1)) begin
        drop_q <= drop_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Wishbone classic master
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WB_IDLE: begin
        if (!fifo_empty) begin
          state_d = WB_BUSY;
        end
      end
      WB_BUSY: begin
        if (wb_ack_i) begin
          state_d = WB_IDLE;
        end
      end
      default: state_d = WB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign wb_cyc_o  = (state_q == WB_BUSY);
  assign wb_stb_o  = (state_q == WB_BUSY);
  assign wb_we_o   = 1'b1;
  assign wb_adr_o  = seq_mem[rd_ptr_q[PTR_W-1:0]];
  assign wb_dat_o  = rec_mem[rd_ptr_q[PTR_W-1:0]];
  assign dropped_o = drop_q;

  a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o)))
    else $error("Wishbone request changed before ack");

endmodule

//--- hw/trace_execute.sv
// EX and WB trace slots; collect register and memory activity and retire one record per instr
`timescale 1ns/1ps

module trace_execute (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  tracer_pkg::dec_evt_t   evt_i,
  input  tracer_pkg::ex_info_t   ex_i,
  input  tracer_pkg::wb_info_t   wb_i,
  output tracer_pkg::trace_rec_t rec_o,
  output logic                   ret_valid_o
);
  import tracer_pkg::*;

  // Record under construction plus the info used to match register writes
  typedef struct packed {
    trace_rec_t rec;
    logic       rd_expected;
    reg_addr_t  rd_addr;
    logic       rd_any;
    logic       is_load;
  } slot_t;

  slot_t ex_slot_q;
  slot_t ex_slot_d;
  slot_t ex_cur;
  slot_t wb_slot_q;
  slot_t wb_slot_d;
  slot_t wb_cur;
  logic  ex_occ_q;
  logic  ex_occ_d;
  logic  wb_occ_q;
  logic  wb_occ_d;
  logic  advance;
  logic  retire;

  function automatic logic rd_match(slot_t s, reg_addr_t addr);
    return s.rd_any || (s.rd_expected && (addr == s.rd_addr));
  endfunction

  function automatic slot_t new_slot(dec_evt_t e);
    slot_t s;
    s                = '0;
    s.rec.pc         = e.pc;
    s.rec.instr      = e.instr;
    s.rec.compressed = e.compressed;
    s.rd_expected    = e.rd_expected;
    s.rd_addr        = e.rd_addr;
    s.rd_any         = e.rd_any;
    s.is_load        = e.is_load;
    return s;
  endfunction

  assign advance = ex_occ_q && ex_i.ex_valid;
  assign retire  = wb_occ_q && wb_i.wb_valid;

  // ------------------------------------------------------------------
  // Attach this cycle's activity to the slots
  // ------------------------------------------------------------------
  always_comb begin
    ex_cur = ex_slot_q;
    if (ex_occ_q && ex_i.reg_we && rd_match(ex_slot_q, ex_i.reg_addr)) begin
      ex_cur.rec.rd_we    = 1'b1;
      ex_cur.rec.rd_addr  = ex_i.reg_addr;
      ex_cur.rec.rd_wdata = ex_i.reg_wdata;
    end
    // Only a granted request counts as an access
    if (ex_occ_q && ex_i.data_req && ex_i.data_gnt) begin
      ex_cur.rec.mem_valid = 1'b1;
      ex_cur.rec.mem_we    = ex_i.data_we;
      ex_cur.rec.mem_addr  = ex_i.data_addr;
      ex_cur.rec.mem_wdata = ex_i.data_we ? ex_i.data_wdata : '0;
    end
  end

  always_comb begin
    wb_cur = wb_slot_q;
    // Load data shows up as a WB-stage write
    if (wb_occ_q && wb_slot_q.is_load && wb_i.reg_we &&
        rd_match(wb_slot_q, wb_i.reg_addr)) begin
      wb_cur.rec.rd_we    = 1'b1;
      wb_cur.rec.rd_addr  = wb_i.reg_addr;
      wb_cur.rec.rd_wdata = wb_i.reg_wdata;
    end
  end

  // ------------------------------------------------------------------
  // Slot movement
  // ------------------------------------------------------------------
  always_comb begin
    ex_occ_d  = ex_occ_q;
    ex_slot_d = ex_cur;
    if (evt_i.valid) begin
      ex_occ_d  = 1'b1;
      ex_slot_d = new_slot(evt_i);
    end else if (advance) begin
      ex_occ_d = 1'b0;
    end

    wb_occ_d  = wb_occ_q;
    wb_slot_d = wb_cur;
    if (advance) begin
      wb_occ_d  = 1'b1;
      wb_slot_d = ex_cur;
    end else if (retire) begin
      wb_occ_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_occ_q <= 1'b0;
      wb_occ_q <= 1'b0;
    end else begin
      ex_occ_q <= ex_occ_d;
      wb_occ_q <= wb_occ_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_slot_q <= ex_slot_d;
    wb_slot_q <= wb_slot_d;
  end

  // Record leaves in the cycle of the retiring edge, WB write included
  assign rec_o       = wb_cur.rec;
  assign ret_valid_o = retire;

  // EX may only move on when WB is free or draining in the same cycle
  a_no_wb_overrun: assert property (@(posedge clk_i) disable iff (!rst_n)
    advance |-> (!wb_occ_q || wb_i.wb_valid))
    else $error("EX advanced into an occupied WB slot");

  a_wb_valid_occupied: assert property (@(posedge clk_i) disable iff (!rst_n)
    wb_i.wb_valid |-> wb_occ_q)
    else $error("wb_valid seen with an empty WB slot");

endmodule

//--- hw/trace_decode.sv
// Decode-stage qualifier; turns a legal decoded instruction into a tracer event with rd info
`timescale 1ns/1ps

module trace_decode (
  input  tracer_pkg::id_info_t id_i,
  output tracer_pkg::dec_evt_t evt_o
);
  import tracer_pkg::*;

  // Compressed quadrants and the funct3 shared by c.lw and c.lwsp
  localparam logic [1:0] C_Q0    = 2'b00;
  localparam logic [1:0] C_Q2    = 2'b10;
  localparam logic [2:0] C_F3_LW = 3'b010;

  logic [6:0] opcode;
  logic       c_load;

  assign opcode = id_i.instr[6:0];

  // c.lw lives in quadrant 0, c.lwsp in quadrant 2
  assign c_load = (id_i.instr[15:13] == C_F3_LW) &&
                  ((id_i.instr[1:0] == C_Q0) || (id_i.instr[1:0] == C_Q2));

  always_comb begin
    evt_o             = '0;
    evt_o.valid       = id_i.id_valid && id_i.is_decoding && !id_i.is_illegal;
    evt_o.pc          = id_i.pc;
    evt_o.instr       = id_i.instr;
    evt_o.compressed  = id_i.compressed;
    evt_o.rd_addr     = id_i.instr[11:7];

    if (id_i.compressed) begin
      // Compressed rd encodings vary, so any write is taken
      evt_o.rd_expected = 1'b1;
      evt_o.rd_any      = 1'b1;
      evt_o.is_load     = c_load;
    end else begin
      // Stores and branches never write a register
      evt_o.rd_expected = !((opcode == OPC_STORE) || (opcode == OPC_BRANCH));
      evt_o.rd_any      = 1'b0;
      evt_o.is_load     = (opcode == OPC_LOAD);
    end
  end

endmodule

//--- hw/tracer_pkg.sv
// Shared widths, core observation structs and record layout; compile before any tracer module
package tracer_pkg;

  // ------------------------------------------------------------------
  // Basic vector types
  // ------------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  seq_t;
  typedef logic [7:0]  drop_cnt_t;

  // ------------------------------------------------------------------
  // Core observation, one struct per pipeline stage
  // ------------------------------------------------------------------
  typedef struct packed {
    logic   id_valid;
    logic   is_decoding;
    logic   is_illegal;
    addr_t  pc;
    instr_t instr;
    logic   compressed;
  } id_info_t;

  typedef struct packed {
    logic      ex_valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    xlen_t     reg_wdata;
    logic      data_req;
    logic      data_gnt;
    logic      data_we;
    addr_t     data_addr;
    xlen_t     data_wdata;
  } ex_info_t;

  typedef struct packed {
    logic      wb_valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    xlen_t     reg_wdata;
  } wb_info_t;

  // ------------------------------------------------------------------
  // Internal events and the retire record
  // ------------------------------------------------------------------
  typedef struct packed {
    logic      valid;
    addr_t     pc;
    instr_t    instr;
    logic      compressed;
    logic      rd_expected;
    reg_addr_t rd_addr;
    logic      rd_any;
    logic      is_load;
  } dec_evt_t;

  typedef struct packed {
    addr_t     pc;
    instr_t    instr;
    logic      compressed;
    logic      rd_we;
    reg_addr_t rd_addr;
    xlen_t     rd_wdata;
    logic      mem_valid;
    logic      mem_we;
    addr_t     mem_addr;
    xlen_t     mem_wdata;
  } trace_rec_t;

  // Record width doubles as the Wishbone data width
  localparam int unsigned REC_W = $bits(trace_rec_t);

  // Major opcodes of 32-bit instructions
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage
